//--- router_pkg.sv
//****************************************
// Router types, port indices and buffer depth
//****************************************
`default_nettype none

package router_pkg;

  // Live ports on the north edge
  localparam int NUM_PORTS = 4;

  // Input FIFO depth, also the credit count of a fresh downstream router
  localparam int BUF_DEPTH = 8;

  // Flit layout
  //   [15:8] payload
  //   [7:4]  destination Y
  //   [3:0]  destination X
  typedef logic [15:0] flit_t;

  // Router address, Y high nibble, X low nibble
  typedef logic [7:0] coord_t;

  // Port index
  typedef logic [1:0] port_t;

  // FIFO pointer and occupancy
  typedef logic [2:0] ptr_t;
  typedef logic [3:0] cnt_t;

  localparam port_t PORT_S = 2'd0;
  localparam port_t PORT_W = 2'd1;
  localparam port_t PORT_E = 2'd2;
  localparam port_t PORT_L = 2'd3;

endpackage

`default_nettype wire

//--- input_buffer.sv
//****************************************
// 8-entry first-word-fall-through input FIFO
//****************************************
`timescale 1ns/100ps
`default_nettype none

module input_buffer (
  input  logic              clk,
  input  logic              rst_n_i,
  input  router_pkg::flit_t buf_data_i,
  input  logic              buf_write_i,
  input  logic              buf_read_i,
  output router_pkg::flit_t buf_data_o,
  output logic              buf_empty_o
);

  router_pkg::flit_t mem [router_pkg::BUF_DEPTH];
  router_pkg::ptr_t  wr_ptr;
  router_pkg::ptr_t  rd_ptr;
  router_pkg::cnt_t  count;
  logic              full;

  always_ff @(posedge clk) begin
    if (buf_write_i) begin
      mem[wr_ptr] <= buf_data_i;
    end
  end

  // Pointers wrap naturally at depth 8
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (buf_write_i) begin
        wr_ptr <= wr_ptr + 3'd1;
      end
      if (buf_read_i) begin
        rd_ptr <= rd_ptr + 3'd1;
      end
      case ({buf_write_i, buf_read_i})
        2'b10:   count <= count + 4'd1;
        2'b01:   count <= count - 4'd1;
        default: count <= count;
      endcase
    end
  end

  // Head of queue visible without a read
  assign buf_data_o  = mem[rd_ptr];
  assign buf_empty_o = (count == '0);
  assign full        = (count == router_pkg::cnt_t'(router_pkg::BUF_DEPTH));

  // Upstream must hold a credit before it sends
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !(buf_write_i && full)
  );

  // Allocator only pops a non-empty queue
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !(buf_read_i && buf_empty_o)
  );

endmodule

`default_nettype wire

//--- credit_counter.sv
//****************************************
// Downstream free-slot counter
//****************************************
`timescale 1ns/100ps
`default_nettype none

module credit_counter (
  input  logic clk,
  input  logic rst_n_i,
  input  logic cc_dec_i,
  input  logic cc_inc_i,
  output logic cc_has_credit_o
);

  router_pkg::cnt_t count;

  // Downstream starts with an empty FIFO
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      count <= router_pkg::cnt_t'(router_pkg::BUF_DEPTH);
    end else begin
      case ({cc_dec_i, cc_inc_i})
        2'b10:   count <= count - 4'd1;
        2'b01:   count <= count + 4'd1;
        default: count <= count;
      endcase
    end
  end

  assign cc_has_credit_o = (count != '0);

  a_no_dec_at_zero: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    cc_dec_i |-> (count != '0)
  );

  // A full count means nothing is left downstream to free
  a_no_inc_at_full: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    cc_inc_i |-> (count != router_pkg::cnt_t'(router_pkg::BUF_DEPTH))
  );

endmodule

`default_nettype wire

//--- switch_allocator.sv
//****************************************
// YX routing and per-output round-robin arbitration
//****************************************
`timescale 1ns/100ps
`default_nettype none

module switch_allocator (
  input  logic                                          clk,
  input  logic                                          rst_n_i,
  input  router_pkg::coord_t                            yx_addr_router_i,
  input  router_pkg::flit_t [router_pkg::NUM_PORTS-1:0] head_flit_i,
  input  logic [router_pkg::NUM_PORTS-1:0]              ib_empty_i,
  input  logic [router_pkg::NUM_PORTS-1:0]              has_credit_i,
  output logic [router_pkg::NUM_PORTS-1:0]              ib_read_o,
  output logic [router_pkg::NUM_PORTS-1:0]              send_o,
  output router_pkg::port_t [router_pkg::NUM_PORTS-1:0] sel_o
);

  typedef enum logic {
    RR_IDLE,
    RR_GRANTED
  } rr_state_e;

  router_pkg::port_t [router_pkg::NUM_PORTS-1:0]   route;
  logic [router_pkg::NUM_PORTS-1:0][router_pkg::NUM_PORTS-1:0] gnt;
  logic [router_pkg::NUM_PORTS-1:0][router_pkg::NUM_PORTS-1:0] gnt_by_in;
  rr_state_e                                       rr_state [router_pkg::NUM_PORTS];
  router_pkg::port_t [router_pkg::NUM_PORTS-1:0]   rr_last;

  // Y first, then X
  always_comb begin
    for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
      if (head_flit_i[i][7:4] > yx_addr_router_i[7:4]) begin
        route[i] = router_pkg::PORT_S;
      end else if (head_flit_i[i][3:0] > yx_addr_router_i[3:0]) begin
        route[i] = router_pkg::PORT_E;
      end else if (head_flit_i[i][3:0] < yx_addr_router_i[3:0]) begin
        route[i] = router_pkg::PORT_W;
      end else begin
        route[i] = router_pkg::PORT_L;
      end
    end
  end

  // gnt is indexed [output][input]
  always_comb begin
    router_pkg::port_t start;
    router_pkg::port_t cand;
    gnt    = '0;
    send_o = '0;
    sel_o  = '0;
    for (int o = 0; o < router_pkg::NUM_PORTS; o++) begin
      // Search starts just after the last winner, or at port 0 before any grant
      start = (rr_state[o] == RR_GRANTED) ? rr_last[o] + 2'd1 : router_pkg::PORT_S;
      for (int k = 0; k < router_pkg::NUM_PORTS; k++) begin
        cand = start + router_pkg::port_t'(k);
        if (has_credit_i[o] && !send_o[o] && !ib_empty_i[cand] &&
            route[cand] == router_pkg::port_t'(o)) begin
          send_o[o]     = 1'b1;
          sel_o[o]      = cand;
          gnt[o][cand]  = 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
      for (int o = 0; o < router_pkg::NUM_PORTS; o++) begin
        gnt_by_in[i][o] = gnt[o][i];
      end
      ib_read_o[i] = |gnt_by_in[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int o = 0; o < router_pkg::NUM_PORTS; o++) begin
        rr_state[o] <= RR_IDLE;
        rr_last[o]  <= router_pkg::PORT_S;
      end
    end else begin
      for (int o = 0; o < router_pkg::NUM_PORTS; o++) begin
        if (send_o[o]) begin
          rr_state[o] <= RR_GRANTED;
          rr_last[o]  <= sel_o[o];
        end
      end
    end
  end

  for (genvar i = 0; i < router_pkg::NUM_PORTS; i++) begin : g_chk
    // Top row, nothing may head north
    a_no_north: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      !ib_empty_i[i] |-> (head_flit_i[i][7:4] >= yx_addr_router_i[7:4])
    );
  end

endmodule

`default_nettype wire

//--- crossbar_switch.sv
//****************************************
// Registered 4x4 crossbar with credit return
//****************************************
`timescale 1ns/100ps
`default_nettype none

module crossbar_switch (
  input  logic                                          clk,
  input  logic                                          rst_n_i,
  input  router_pkg::flit_t [router_pkg::NUM_PORTS-1:0] cs_data_i,
  input  router_pkg::port_t [router_pkg::NUM_PORTS-1:0] cs_sel_i,
  input  logic [router_pkg::NUM_PORTS-1:0]              cs_send_i,
  input  logic [router_pkg::NUM_PORTS-1:0]              cs_read_i,
  output router_pkg::flit_t [router_pkg::NUM_PORTS-1:0] cs_data_o,
  output logic [router_pkg::NUM_PORTS-1:0]              cs_valid_o,
  output logic [router_pkg::NUM_PORTS-1:0]              cs_credit_o
);

  // Output data holds between flits
  always_ff @(posedge clk) begin
    for (int o = 0; o < router_pkg::NUM_PORTS; o++) begin
      if (cs_send_i[o]) begin
        cs_data_o[o] <= cs_data_i[cs_sel_i[o]];
      end
    end
  end

  // A pop frees one upstream slot, returned with the flit's valid
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cs_valid_o  <= '0;
      cs_credit_o <= '0;
    end else begin
      cs_valid_o  <= cs_send_i;
      cs_credit_o <= cs_read_i;
    end
  end

endmodule

`default_nettype wire

//--- n_edge_router.sv
//****************************************
// North-edge mesh router, top level
//****************************************
`timescale 1ns/100ps
`default_nettype none

module n_edge_router (
  input  logic               clk,
  input  logic               rst_n_i,
  input  router_pkg::coord_t yx_addr_router_i,

  input  router_pkg::flit_t  s_data_i,
  input  router_pkg::flit_t  w_data_i,
  input  router_pkg::flit_t  e_data_i,
  input  router_pkg::flit_t  l_data_i,
  input  logic               s_valid_i,
  input  logic               w_valid_i,
  input  logic               e_valid_i,
  input  logic               l_valid_i,
  input  logic               s_credit_i,
  input  logic               w_credit_i,
  input  logic               e_credit_i,
  input  logic               l_credit_i,

  output router_pkg::flit_t  s_data_o,
  output router_pkg::flit_t  w_data_o,
  output router_pkg::flit_t  e_data_o,
  output router_pkg::flit_t  l_data_o,
  output logic               s_valid_o,
  output logic               w_valid_o,
  output logic               e_valid_o,
  output logic               l_valid_o,
  output logic               s_credit_o,
  output logic               w_credit_o,
  output logic               e_credit_o,
  output logic               l_credit_o
);

  router_pkg::flit_t [router_pkg::NUM_PORTS-1:0] head;
  router_pkg::port_t [router_pkg::NUM_PORTS-1:0] sel;
  logic [router_pkg::NUM_PORTS-1:0]              ib_empty;
  logic [router_pkg::NUM_PORTS-1:0]              ib_read;
  logic [router_pkg::NUM_PORTS-1:0]              has_credit;
  logic [router_pkg::NUM_PORTS-1:0]              send;

  // Input FIFOs
  input_buffer ib_s (
    .clk(clk), .rst_n_i(rst_n_i),
    .buf_data_i(s_data_i), .buf_write_i(s_valid_i),
    .buf_read_i(ib_read[router_pkg::PORT_S]),
    .buf_data_o(head[router_pkg::PORT_S]),
    .buf_empty_o(ib_empty[router_pkg::PORT_S])
  );

  input_buffer ib_w (
    .clk(clk), .rst_n_i(rst_n_i),
    .buf_data_i(w_data_i), .buf_write_i(w_valid_i),
    .buf_read_i(ib_read[router_pkg::PORT_W]),
    .buf_data_o(head[router_pkg::PORT_W]),
    .buf_empty_o(ib_empty[router_pkg::PORT_W])
  );

  input_buffer ib_e (
    .clk(clk), .rst_n_i(rst_n_i),
    .buf_data_i(e_data_i), .buf_write_i(e_valid_i),
    .buf_read_i(ib_read[router_pkg::PORT_E]),
    .buf_data_o(head[router_pkg::PORT_E]),
    .buf_empty_o(ib_empty[router_pkg::PORT_E])
  );

  input_buffer ib_l (
    .clk(clk), .rst_n_i(rst_n_i),
    .buf_data_i(l_data_i), .buf_write_i(l_valid_i),
    .buf_read_i(ib_read[router_pkg::PORT_L]),
    .buf_data_o(head[router_pkg::PORT_L]),
    .buf_empty_o(ib_empty[router_pkg::PORT_L])
  );

  // One counter per output
  credit_counter cc_s (
    .clk(clk), .rst_n_i(rst_n_i),
    .cc_dec_i(send[router_pkg::PORT_S]), .cc_inc_i(s_credit_i),
    .cc_has_credit_o(has_credit[router_pkg::PORT_S])
  );

  credit_counter cc_w (
    .clk(clk), .rst_n_i(rst_n_i),
    .cc_dec_i(send[router_pkg::PORT_W]), .cc_inc_i(w_credit_i),
    .cc_has_credit_o(has_credit[router_pkg::PORT_W])
  );

  credit_counter cc_e (
    .clk(clk), .rst_n_i(rst_n_i),
    .cc_dec_i(send[router_pkg::PORT_E]), .cc_inc_i(e_credit_i),
    .cc_has_credit_o(has_credit[router_pkg::PORT_E])
  );

  credit_counter cc_l (
    .clk(clk), .rst_n_i(rst_n_i),
    .cc_dec_i(send[router_pkg::PORT_L]), .cc_inc_i(l_credit_i),
    .cc_has_credit_o(has_credit[router_pkg::PORT_L])
  );

  switch_allocator sa (
    .clk(clk), .rst_n_i(rst_n_i),
    .yx_addr_router_i(yx_addr_router_i),
    .head_flit_i(head), .ib_empty_i(ib_empty), .has_credit_i(has_credit),
    .ib_read_o(ib_read), .send_o(send), .sel_o(sel)
  );

  // Port order in the vectors is l, e, w, s from MSB down
  crossbar_switch cs (
    .clk(clk), .rst_n_i(rst_n_i),
    .cs_data_i(head), .cs_sel_i(sel), .cs_send_i(send), .cs_read_i(ib_read),
    .cs_data_o({l_data_o, e_data_o, w_data_o, s_data_o}),
    .cs_valid_o({l_valid_o, e_valid_o, w_valid_o, s_valid_o}),
    .cs_credit_o({l_credit_o, e_credit_o, w_credit_o, s_credit_o})
  );

endmodule

`default_nettype wire

//--- tb_n_edge_router.sv
//****************************************
// Testbench for the north-edge router
//****************************************
`timescale 1ns/100ps
`default_nettype none

module tb_n_edge_router;

  logic                      clk;
  logic                      rst_n;
  router_pkg::coord_t        yx_addr;
  router_pkg::flit_t         data_in  [4];
  router_pkg::flit_t         data_out [4];
  logic [3:0]                valid_in;
  logic [3:0]                credit_in;
  logic [3:0]                valid_out;
  logic [3:0]                credit_out;
  logic [3:0]                hold;

  // Scoreboard indexed [source][output]
  router_pkg::flit_t exp_q [4][4][$];
  int                inj_q [4][4][$];

  int cyc = 0;
  int post_rst = 0;
  int limit_cycles = 0;
  int out_total = 0;
  int probe_cyc = -1;
  int probe_src;
  int probe_out;
  int tb_credit [4];
  int pending [4];
  int ret_delay [4];
  int credit_cnt [4];
  int inj_cnt [4];
  int src_out [4];
  int held_leaves [4];
  int last_src [4];
  int last_cyc [4];
  byte op_q [$];
  int a_q [$];
  int b_q [$];
  int c_q [$];

  n_edge_router dut_i (
    .clk(clk), .rst_n_i(rst_n), .yx_addr_router_i(yx_addr),
    .s_data_i(data_in[0]), .w_data_i(data_in[1]),
    .e_data_i(data_in[2]), .l_data_i(data_in[3]),
    .s_valid_i(valid_in[0]), .w_valid_i(valid_in[1]),
    .e_valid_i(valid_in[2]), .l_valid_i(valid_in[3]),
    .s_credit_i(credit_in[0]), .w_credit_i(credit_in[1]),
    .e_credit_i(credit_in[2]), .l_credit_i(credit_in[3]),
    .s_data_o(data_out[0]), .w_data_o(data_out[1]),
    .e_data_o(data_out[2]), .l_data_o(data_out[3]),
    .s_valid_o(valid_out[0]), .w_valid_o(valid_out[1]),
    .e_valid_o(valid_out[2]), .l_valid_o(valid_out[3]),
    .s_credit_o(credit_out[0]), .w_credit_o(credit_out[1]),
    .e_credit_o(credit_out[2]), .l_credit_o(credit_out[3])
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc++;
    if (!rst_n) post_rst = 0;
    else post_rst++;
  end

  // YX rule, south is 0, west 1, east 2, local 3
  function automatic int route_of(router_pkg::flit_t f, router_pkg::coord_t a);
    if (f[7:4] > a[7:4]) return 0;
    if (f[3:0] > a[3:0]) return 2;
    if (f[3:0] < a[3:0]) return 1;
    return 3;
  endfunction

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_flit(router_pkg::flit_t got, router_pkg::flit_t want, string what);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, want);
      stop_run();
    end
  endtask

  task automatic check_count(router_pkg::cnt_t got, router_pkg::cnt_t want, string what);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, want);
      stop_run();
    end
  endtask

  task automatic inject(int src, router_pkg::flit_t f, bit probe);
    int o;
    while (tb_credit[src] == 0) @(negedge clk);
    o = route_of(f, yx_addr);
    data_in[src]  = f;
    valid_in[src] = 1'b1;
    tb_credit[src]--;
    inj_cnt[src]++;
    src_out[src]++;
    out_total++;
    exp_q[src][o].push_back(f);
    inj_q[src][o].push_back(cyc);
    if (probe) begin
      probe_cyc = cyc;
      probe_src = src;
      probe_out = o;
    end
    @(negedge clk);
    valid_in = '0;
  endtask

  // Downstream model returns one credit per flit after a short random delay
  always @(negedge clk) begin
    for (int o = 0; o < 4; o++) begin
      credit_in[o] = 1'b0;
      if (rst_n && !hold[o] && pending[o] > 0) begin
        if (ret_delay[o] == 0) begin
          credit_in[o] = 1'b1;
          pending[o]--;
          ret_delay[o] = int'($urandom % 3);
        end else begin
          ret_delay[o]--;
        end
      end
    end
  end

  always @(negedge clk) begin
    int src;
    router_pkg::flit_t want;
    if (post_rst <= 1) begin
      if (valid_out !== '0 || credit_out !== '0) begin
        $display("Valid or credit output was high during or right after reset");
        stop_run();
      end
    end else begin
      if (probe_cyc >= 0 && cyc == probe_cyc + 2) begin
        if (!valid_out[probe_out] || !credit_out[probe_src]) begin
          $display("Uncontended flit did not leave two edges after injection with its credit");
          stop_run();
        end
        probe_cyc = -1;
      end
      for (int o = 0; o < 4; o++) begin
        if (valid_out[o]) begin
          src = int'(data_out[o][15:14]);
          if (exp_q[src][o].size() == 0) begin
            $display("Flit %h left on output %0d where none was expected", data_out[o], o);
            stop_run();
          end
          // A head waiting since the last grant must beat a repeat winner
          if (last_src[o] == src) begin
            for (int s = 0; s < 4; s++) begin
              if (s != src && exp_q[s][o].size() > 0 && exp_q[s][o].size() == src_out[s] &&
                  inj_q[s][o][0] <= last_cyc[o] - 2) begin
                $display("Output %0d served input %0d twice while input %0d waited", o, src, s);
                stop_run();
              end
            end
          end
          want = exp_q[src][o].pop_front();
          void'(inj_q[src][o].pop_front());
          check_flit(data_out[o], want, $sformatf("output %0d from input %0d", o, src));
          last_src[o] = src;
          last_cyc[o] = cyc;
          out_total--;
          src_out[src]--;
          pending[o]++;
          if (hold[o]) begin
            held_leaves[o]++;
            if (held_leaves[o] > router_pkg::BUF_DEPTH) begin
              $display("More flits left output %0d than it had credits for", o);
              stop_run();
            end
          end
        end
      end
      for (int i = 0; i < 4; i++) begin
        if (credit_out[i]) begin
          credit_cnt[i]++;
          tb_credit[i]++;
        end
      end
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout after %0d cycles with %0d flits still in flight", limit_cycles, out_total);
    stop_run();
  end

  initial begin
    int fd;
    int r;
    int n;
    int a;
    int b;
    int c;
    int total_flits;
    string line;
    string op;
    void'($urandom(46));
    rst_n     = 1'b0;
    yx_addr   = '0;
    valid_in  = '0;
    credit_in = '0;
    hold      = '0;
    total_flits = 0;
    for (int i = 0; i < 4; i++) begin
      data_in[i]     = '0;
      tb_credit[i]   = router_pkg::BUF_DEPTH;
      pending[i]     = 0;
      ret_delay[i]   = 0;
      credit_cnt[i]  = 0;
      inj_cnt[i]     = 0;
      src_out[i]     = 0;
      held_leaves[i] = 0;
      last_src[i]    = -1;
      last_cyc[i]    = 0;
    end

    fd = $fopen("n_edge_router_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file n_edge_router_patterns.txt");
      stop_run();
    end
    while (!$feof(fd)) begin
      line = "";
      r = $fgets(line, fd);
      if (r > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h", op, a, b, c);
        if (n == 4 && op == "A") begin
          yx_addr = router_pkg::coord_t'(a);
        end else if (n == 4) begin
          op_q.push_back(byte'(op.getc(0)));
          a_q.push_back(a);
          b_q.push_back(b);
          c_q.push_back(c);
          if (op == "F" || op == "P") total_flits += c;
        end
      end
    end
    $fclose(fd);
    limit_cycles = total_flits * 40 + 500;

    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    for (int idx = 0; idx < op_q.size(); idx++) begin
      case (op_q[idx])
        "F", "P": begin
          for (int k = 0; k < c_q[idx]; k++) begin
            inject(a_q[idx], router_pkg::flit_t'(b_q[idx] + (k << 8)),
                   op_q[idx] == "P" && k == 0);
          end
        end
        "H": begin
          hold[a_q[idx]]        = 1'b1;
          held_leaves[a_q[idx]] = 0;
        end
        "R": hold[a_q[idx]] = 1'b0;
        "W": repeat (a_q[idx]) @(negedge clk);
        default: ;
      endcase
    end

    while (out_total != 0) @(negedge clk);
    @(negedge clk);
    for (int i = 0; i < 4; i++) begin
      check_count(router_pkg::cnt_t'(credit_cnt[i]), router_pkg::cnt_t'(inj_cnt[i]),
                  $sformatf("credit pulses on input %0d", i));
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- n_edge_router_patterns.txt
# op a b c, all hex; A addr x x | F,P src flit count (P probes latency)
# H,R output x x holds or releases credit returns | W cycles x x
A 03 0 0
P 03 c105 1
W 04 0 0
F 00 0113 3
F 01 4203 2
F 02 8300 2
F 03 c006 2
W 0a 0 0
H 00 0 0
F 02 8a1f 8
W 0c 0 0
F 00 1023 4
F 01 5042 4
W 0a 0 0
R 00 0 0
W 0a 0 0
H 02 0 0
F 03 e00c 6
F 01 6009 3
W 08 0 0
R 02 0 0

//--- n_edge_router.f
router_pkg.sv
input_buffer.sv
credit_counter.sv
switch_allocator.sv
crossbar_switch.sv
n_edge_router.sv
tb_n_edge_router.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_n_edge_router -f n_edge_router.f -o sim
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Verification passed$"; then
  exit 0
fi
exit 1
